// File: hdl/aquila_defines.svh
`ifndef AQUILA_DEFINES_SVH
`define AQUILA_DEFINES_SVH

// ---------------------------------------------------------------------------
// Bus geometry
// ---------------------------------------------------------------------------
`define DATA_WIDTH      32

// Scratchpad depth in words, word address width follows from it
`define TCM_WORDS       1024
`define TCM_AW          10

// Upper nibble of the data address
`define SEG_TCM         4'h0
`define SEG_DEVICE      4'hC
`define SEG_SYSDEV      4'hF

// ---------------------------------------------------------------------------
// CLINT register map, word index taken from address bits 4:2
// ---------------------------------------------------------------------------
`define CLINT_AW        3
`define CLINT_MTIME_LO  3'd0
`define CLINT_MTIME_HI  3'd1
`define CLINT_CMP_LO    3'd2
`define CLINT_CMP_HI    3'd3
`define CLINT_MSIP      3'd4

`endif

// File: hdl/aquila_pkg.sv
package aquila_pkg;

    // -----------------------------------------------------------------------
    // Data address, seen as memory word or as system device register
    // -----------------------------------------------------------------------

    // Memory view for TCM, DRAM and device segments
    typedef struct packed {
        logic [3:0]  seg;
        logic [25:0] word;
        logic [1:0]  byte_off;
    } mem_addr_t;

    // System device view for the 0xF segment
    typedef struct packed {
        logic [3:0]  seg;
        logic [7:0]  rsvd_hi;
        logic [3:0]  dev_sel;     // 0 selects the CLINT
        logic [10:0] rsvd_lo;
        logic [2:0]  reg_idx;
        logic [1:0]  byte_off;
    } sysdev_addr_t;

    typedef union packed {
        mem_addr_t    mem;
        sysdev_addr_t sysdev;
    } data_addr_u;

    // Bus controller states
    typedef enum logic [1:0] {
        IDLE,
        LOCAL,
        DEVICE
    } bus_state_e;

endpackage

// File: hdl/local_bus_if.sv
`timescale 1ns/1ps
`include "aquila_defines.svh"

// Single-cycle local bus between the controller and an on-chip slave
// Slave answers with a one-cycle ready pulse in the cycle after en
interface local_bus_if #(
    parameter int AW = `TCM_AW
);
    logic                     en;
    logic                     we;
    logic [`DATA_WIDTH/8-1:0] be;
    logic [AW-1:0]            addr;      // Word address inside the slave
    logic [`DATA_WIDTH-1:0]   wdata;
    logic [`DATA_WIDTH-1:0]   rdata;
    logic                     ready;

    modport master (
        output en, we, be, addr, wdata,
        input  rdata, ready
    );

    modport slave (
        input  en, we, be, addr, wdata,
        output rdata, ready
    );
endinterface

// File: hdl/mtime_counter.sv
`timescale 1ns/1ps
`include "aquila_defines.svh"

module mtime_counter (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   load_lo_i,
    input  logic                   load_hi_i,
    input  logic [`DATA_WIDTH-1:0] load_data_i,
    output logic [63:0]            mtime_o
);

    logic [63:0] mtime_r;

    // -----------------------------------------------------------------------
    // Free-running timer, a half-word load replaces the increment
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtime_r <= '0;
        end else if (load_lo_i) begin
            // Upper half kept
            mtime_r <= {mtime_r[63:32], load_data_i};
        end else if (load_hi_i) begin
            mtime_r <= {load_data_i, mtime_r[31:0]};
        end else begin
            // Wraps to zero after all ones
            mtime_r <= mtime_r + 64'd1;
        end
    end

    assign mtime_o = mtime_r;

endmodule

// File: hdl/clint_regs.sv
`timescale 1ns/1ps
`include "aquila_defines.svh"

module clint_regs (
    input  logic       clk_i,
    input  logic       reset_i,
    local_bus_if.slave bus,
    output logic       tmr_irq_o,
    output logic       sft_irq_o
);

    logic                   wr;
    logic [63:0]            mtime;
    logic [63:0]            mtimecmp_r;
    logic                   msip_r;
    logic                   tmr_irq_r;
    logic [`DATA_WIDTH-1:0] rdata_r;
    logic                   ready_r;

    assign wr = bus.en && bus.we;

    // -----------------------------------------------------------------------
    // Machine timer
    // -----------------------------------------------------------------------
    mtime_counter mtime0 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .load_lo_i   (wr && (bus.addr == `CLINT_MTIME_LO)),
        .load_hi_i   (wr && (bus.addr == `CLINT_MTIME_HI)),
        .load_data_i (bus.wdata),
        .mtime_o     (mtime)
    );

    // -----------------------------------------------------------------------
    // Compare and software interrupt registers, full-word writes
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtimecmp_r <= '1;
            msip_r     <= 1'b0;
            tmr_irq_r  <= 1'b0;
        end else begin
            if (wr && (bus.addr == `CLINT_CMP_LO)) begin
                mtimecmp_r[31:0] <= bus.wdata;
            end
            if (wr && (bus.addr == `CLINT_CMP_HI)) begin
                mtimecmp_r[63:32] <= bus.wdata;
            end
            if (wr && (bus.addr == `CLINT_MSIP)) begin
                msip_r <= bus.wdata[0];
            end
            tmr_irq_r <= (mtime >= mtimecmp_r);
        end
    end

    // Read mux, registered with the ready pulse
    always_ff @(posedge clk_i) begin
        if (bus.en) begin
            case (bus.addr)
                `CLINT_MTIME_LO: rdata_r <= mtime[31:0];
                `CLINT_MTIME_HI: rdata_r <= mtime[63:32];
                `CLINT_CMP_LO:   rdata_r <= mtimecmp_r[31:0];
                `CLINT_CMP_HI:   rdata_r <= mtimecmp_r[63:32];
                `CLINT_MSIP:     rdata_r <= {{(`DATA_WIDTH-1){1'b0}}, msip_r};
                default:         rdata_r <= '0;   // indexes 5 to 7
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ready_r <= 1'b0;
        end else begin
            ready_r <= bus.en;
        end
    end

    assign bus.rdata = rdata_r;
    assign bus.ready = ready_r;
    assign tmr_irq_o = tmr_irq_r;
    assign sft_irq_o = msip_r;

    // Registered read path holds one answer, so requests come spaced
    a_en_spaced: assert property (
        @(posedge clk_i) disable iff (reset_i) bus.en |=> !bus.en
    );

endmodule

// File: hdl/tcm_ram.sv
`timescale 1ns/1ps
`include "aquila_defines.svh"

module tcm_ram (
    input logic        clk_i,
    input logic        reset_i,
    local_bus_if.slave bus
);

    // Single-ported scratchpad, one word per entry
    logic [`DATA_WIDTH-1:0] mem [`TCM_WORDS];

    logic [`DATA_WIDTH-1:0] rdata_r;
    logic                   ready_r;

    // -----------------------------------------------------------------------
    // Array access
    // -----------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (bus.en) begin
            if (bus.we) begin
                // Byte lanes written under their enables
                for (int i = 0; i < `DATA_WIDTH/8; i++) begin
                    if (bus.be[i]) begin
                        mem[bus.addr][8*i +: 8] <= bus.wdata[8*i +: 8];
                    end
                end
            end
            // Old contents on a write cycle
            rdata_r <= mem[bus.addr];
        end
    end

    // One-cycle response pulse
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ready_r <= 1'b0;
        end else begin
            ready_r <= bus.en;
        end
    end

    assign bus.rdata = rdata_r;
    assign bus.ready = ready_r;

    // Single response register, the controller waits for each answer
    a_en_spaced: assert property (
        @(posedge clk_i) disable iff (reset_i) bus.en |=> !bus.en
    );

endmodule

// File: hdl/data_bus_ctrl.sv
`timescale 1ns/1ps
`include "aquila_defines.svh"

module data_bus_ctrl
    import aquila_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     reset_i,

    // Core data request, one access in flight
    input  logic                     req_i,
    input  data_addr_u               addr_i,
    input  logic                     rw_i,
    input  logic [`DATA_WIDTH/8-1:0] be_i,
    input  logic [`DATA_WIDTH-1:0]   wdata_i,
    output logic                     ready_o,
    output logic [`DATA_WIDTH-1:0]   rdata_o,

    // Uncached device master port
    output logic                     dev_strobe_o,
    output logic [`DATA_WIDTH-1:0]   dev_addr_o,
    output logic                     dev_rw_o,
    output logic [`DATA_WIDTH/8-1:0] dev_be_o,
    output logic [`DATA_WIDTH-1:0]   dev_wdata_o,
    input  logic                     dev_ready_i,
    input  logic [`DATA_WIDTH-1:0]   dev_rdata_i,

    // Local slaves
    local_bus_if.master              tcm_m,
    local_bus_if.master              clint_m
);

    bus_state_e state_r;
    bus_state_e state_nx;

    logic req_idle;
    logic is_tcm;
    logic is_dev;
    logic is_clint;

    // Slave owning the access in LOCAL, neither means unmapped
    logic sel_tcm_r;
    logic sel_clint_r;

    // -----------------------------------------------------------------------
    // Request decode
    // -----------------------------------------------------------------------
    assign req_idle = req_i && (state_r == IDLE);
    assign is_tcm   = (addr_i.mem.seg == `SEG_TCM);
    assign is_dev   = (addr_i.mem.seg == `SEG_DEVICE);
    // Only select 0 of the system segment is backed, the CLINT
    assign is_clint = (addr_i.sysdev.seg == `SEG_SYSDEV) && (addr_i.sysdev.dev_sel == 4'h0);

    // Local slave requests share address and data, en picks the target
    assign tcm_m.en      = req_idle && is_tcm;
    assign tcm_m.we      = rw_i;
    assign tcm_m.be      = be_i;
    assign tcm_m.addr    = addr_i.mem.word[`TCM_AW-1:0];
    assign tcm_m.wdata   = wdata_i;

    assign clint_m.en    = req_idle && is_clint;
    assign clint_m.we    = rw_i;
    assign clint_m.be    = be_i;
    assign clint_m.addr  = addr_i.sysdev.reg_idx;
    assign clint_m.wdata = wdata_i;

    // Device port sees the request in the strobe cycle
    assign dev_strobe_o = req_idle && is_dev;
    assign dev_addr_o   = is_dev ? addr_i : '0;
    assign dev_rw_o     = rw_i && is_dev;
    assign dev_be_o     = be_i;
    assign dev_wdata_o  = is_dev ? wdata_i : '0;

    // -----------------------------------------------------------------------
    // FSM
    // -----------------------------------------------------------------------
    always_comb begin
        state_nx = state_r;
        case (state_r)
            IDLE: begin
                if (req_i) begin
                    state_nx = is_dev ? DEVICE : LOCAL;
                end
            end
            LOCAL: begin
                if (ready_o) begin
                    state_nx = IDLE;
                end
            end
            DEVICE: begin
                // Variable latency, wait for the device
                if (dev_ready_i) begin
                    state_nx = IDLE;
                end
            end
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r     <= IDLE;
            sel_tcm_r   <= 1'b0;
            sel_clint_r <= 1'b0;
        end else begin
            state_r <= state_nx;
            if (req_idle) begin
                sel_tcm_r   <= is_tcm;
                sel_clint_r <= is_clint;
            end
        end
    end

    // -----------------------------------------------------------------------
    // Response mux back to the core
    // -----------------------------------------------------------------------
    always_comb begin
        ready_o = 1'b0;
        rdata_o = '0;
        case (state_r)
            LOCAL: begin
                if (sel_tcm_r) begin
                    ready_o = tcm_m.ready;
                    rdata_o = tcm_m.rdata;
                end else if (sel_clint_r) begin
                    ready_o = clint_m.ready;
                    rdata_o = clint_m.rdata;
                end else begin
                    // DRAM or unknown system device, answered with zero
                    ready_o = 1'b1;
                end
            end
            DEVICE: begin
                ready_o = dev_ready_i;
                rdata_o = dev_rdata_i;
            end
            default: begin
                ready_o = 1'b0;
            end
        endcase
    end

    // Core must hold off until the previous access has completed
    a_req_only_idle: assert property (
        @(posedge clk_i) disable iff (reset_i) req_i |-> (state_r == IDLE)
    );

    // A local slave answers only for the access steered to it
    a_tcm_ready_owned: assert property (
        @(posedge clk_i) disable iff (reset_i)
            tcm_m.ready |-> (state_r == LOCAL) && sel_tcm_r
    );

    a_clint_ready_owned: assert property (
        @(posedge clk_i) disable iff (reset_i)
            clint_m.ready |-> (state_r == LOCAL) && sel_clint_r
    );

endmodule

// File: hdl/aquila_data_top.sv
`timescale 1ns/1ps
`include "aquila_defines.svh"

module aquila_data_top (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // Core data request and response
    input  logic                     req_i,
    input  logic [`DATA_WIDTH-1:0]   addr_i,
    input  logic                     rw_i,
    input  logic [`DATA_WIDTH/8-1:0] be_i,
    input  logic [`DATA_WIDTH-1:0]   wdata_i,
    output logic                     ready_o,
    output logic [`DATA_WIDTH-1:0]   rdata_o,

    // Device master port
    output logic                     dev_strobe_o,
    output logic [`DATA_WIDTH-1:0]   dev_addr_o,
    output logic                     dev_rw_o,
    output logic [`DATA_WIDTH/8-1:0] dev_be_o,
    output logic [`DATA_WIDTH-1:0]   dev_wdata_o,
    input  logic                     dev_ready_i,
    input  logic [`DATA_WIDTH-1:0]   dev_rdata_i,

    // CLINT interrupt lines
    output logic                     tmr_irq_o,
    output logic                     sft_irq_o
);

    // -----------------------------------------------------------------------
    // Local buses, TCM word address and CLINT register index
    // -----------------------------------------------------------------------
    local_bus_if #(.AW(`TCM_AW))   tcm_bus ();
    local_bus_if #(.AW(`CLINT_AW)) clint_bus ();

    data_bus_ctrl ctrl0 (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .rw_i         (rw_i),
        .be_i         (be_i),
        .wdata_i      (wdata_i),
        .ready_o      (ready_o),
        .rdata_o      (rdata_o),
        .dev_strobe_o (dev_strobe_o),
        .dev_addr_o   (dev_addr_o),
        .dev_rw_o     (dev_rw_o),
        .dev_be_o     (dev_be_o),
        .dev_wdata_o  (dev_wdata_o),
        .dev_ready_i  (dev_ready_i),
        .dev_rdata_i  (dev_rdata_i),
        .tcm_m        (tcm_bus.master),
        .clint_m      (clint_bus.master)
    );

    // Scratchpad at 0x0000_0000
    tcm_ram tcm0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .bus     (tcm_bus.slave)
    );

    // CLINT at 0xF000_0000
    clint_regs clint0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .bus       (clint_bus.slave),
        .tmr_irq_o (tmr_irq_o),
        .sft_irq_o (sft_irq_o)
    );

endmodule

// File: verification/bus_checker.sv
`timescale 1ns/1ps
`include "aquila_defines.svh"

module bus_checker (
    input logic                     clk_i,
    input logic                     reset_i,
    // Core side of the DUT
    input logic                     req_i,
    input logic [`DATA_WIDTH-1:0]   addr_i,
    input logic                     rw_i,
    input logic [`DATA_WIDTH/8-1:0] be_i,
    input logic [`DATA_WIDTH-1:0]   wdata_i,
    input logic                     ready_i,
    // Device master port of the DUT
    input logic                     dev_strobe_i,
    input logic [`DATA_WIDTH-1:0]   dev_addr_i,
    input logic                     dev_rw_i,
    input logic [`DATA_WIDTH/8-1:0] dev_be_i,
    input logic [`DATA_WIDTH-1:0]   dev_wdata_i
);

    int    errors = 0;
    int    tests = 0;
    int    failed_tests = 0;
    int    test_errors = 0;
    string test_name = "";

    // Negedge count, used for response latency
    int    cycle = 0;
    int    req_cycle = 0;
    logic  pending = 1'b0;
    logic  req_dev = 1'b0;

    // -----------------------------------------------------------------------
    // Reporting
    // -----------------------------------------------------------------------
    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", tests, test_name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: FAILED with %0d errors", tests, test_name, test_errors);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        test_errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    task automatic check_value(input string name, input logic [`DATA_WIDTH-1:0] got,
                               input logic [`DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_range(input string name, input logic [`DATA_WIDTH-1:0] got,
                               input logic [`DATA_WIDTH-1:0] lo,
                               input logic [`DATA_WIDTH-1:0] hi);
        if (got < lo || got > hi) begin
            errors++;
            test_errors++;
            $display("Error at %0t ns: %s is %h, expected %h to %h", $time, name, got, lo, hi);
        end
    endtask

    // -----------------------------------------------------------------------
    // Bus monitor, sampled mid-cycle where all DUT outputs are settled
    // -----------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (!reset_i) begin
            cycle++;
            if (req_i) begin
                pending   = 1'b1;
                req_cycle = cycle;
                req_dev   = (addr_i[31:28] == `SEG_DEVICE);
                // Device segment shows the whole request in the strobe cycle
                if (req_dev) begin
                    check_value("dev_strobe_o", {31'b0, dev_strobe_i}, 32'd1);
                    check_value("dev_addr_o", dev_addr_i, addr_i);
                    check_value("dev_rw_o", {31'b0, dev_rw_i}, {31'b0, rw_i});
                    check_value("dev_be_o", {28'b0, dev_be_i}, {28'b0, be_i});
                    check_value("dev_wdata_o", dev_wdata_i, wdata_i);
                end else begin
                    check_value("dev_strobe_o", {31'b0, dev_strobe_i}, 32'd0);
                end
            end else if (dev_strobe_i) begin
                note_failure("dev_strobe_o pulsed without a core request");
            end
            if (ready_i) begin
                if (!pending) begin
                    note_failure("ready_o pulsed with no access in flight");
                end else if (!req_dev && (cycle - req_cycle) != 1) begin
                    // TCM, CLINT and unmapped answers take exactly one cycle
                    note_failure($sformatf("ready_o came %0d cycles after req_i, not 1",
                                           cycle - req_cycle));
                end
                pending = 1'b0;
            end
        end
    end

endmodule

// File: verification/tb_aquila_data.sv
`timescale 1ns/1ps
`include "aquila_defines.svh"

module tb_aquila_data;

    logic                     clk_i;
    logic                     reset_i;
    logic                     req_i;
    logic [`DATA_WIDTH-1:0]   addr_i;
    logic                     rw_i;
    logic [`DATA_WIDTH/8-1:0] be_i;
    logic [`DATA_WIDTH-1:0]   wdata_i;
    logic                     ready_o;
    logic [`DATA_WIDTH-1:0]   rdata_o;
    logic                     dev_strobe_o;
    logic [`DATA_WIDTH-1:0]   dev_addr_o;
    logic                     dev_rw_o;
    logic [`DATA_WIDTH/8-1:0] dev_be_o;
    logic [`DATA_WIDTH-1:0]   dev_wdata_o;
    logic                     dev_ready_i;
    logic [`DATA_WIDTH-1:0]   dev_rdata_i;
    logic                     tmr_irq_o;
    logic                     sft_irq_o;

    aquila_data_top dut0 (.*);

    bus_checker checker0 (
        .clk_i (clk_i), .reset_i (reset_i), .req_i (req_i), .addr_i (addr_i),
        .rw_i (rw_i), .be_i (be_i), .wdata_i (wdata_i), .ready_i (ready_o),
        .dev_strobe_i (dev_strobe_o), .dev_addr_i (dev_addr_o), .dev_rw_i (dev_rw_o),
        .dev_be_i (dev_be_o), .dev_wdata_i (dev_wdata_o)
    );

    // 100 ns clock
    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    // -----------------------------------------------------------------------
    // Core driver and device model
    // -----------------------------------------------------------------------
    task automatic run_access(input logic wr, input logic [31:0] a, input logic [3:0] b,
                              input logic [31:0] wd, output logic [31:0] rd,
                              output logic done);
        int waited;
        waited = 0;
        done   = 1'b0;
        rd     = '0;
        @(posedge clk_i);
        #5;
        req_i   = 1'b1;
        addr_i  = a;
        rw_i    = wr;
        be_i    = b;
        wdata_i = wd;
        @(posedge clk_i);
        #5;
        req_i = 1'b0;
        rw_i  = 1'b0;
        // Response sampled mid-cycle, at most 50 cycles
        while (!done && waited < 50) begin
            @(negedge clk_i);
            if (ready_o) begin
                done = 1'b1;
                rd   = rdata_o;
            end
            waited++;
        end
    endtask

    // Interrupt line must reach its level within 2 cycles
    task automatic wait_irq(input logic use_tmr, input logic want, output logic level);
        int waited;
        waited = 0;
        level  = use_tmr ? tmr_irq_o : sft_irq_o;
        while (level != want && waited < 2) begin
            @(negedge clk_i);
            level = use_tmr ? tmr_irq_o : sft_irq_o;
            waited++;
        end
    endtask

    // Device answers after 1 to 8 cycles with the address XOR a fixed mask
    initial begin : device_model
        int unsigned delay;
        logic [31:0] req_addr;
        // Fixed seed for the response delays
        void'($urandom(32'h502a));
        forever begin
            @(negedge clk_i);
            if (dev_strobe_o) begin
                req_addr = dev_addr_o;
                delay    = 1 + ($urandom % 8);
                repeat (delay) @(posedge clk_i);
                #5;
                dev_ready_i = 1'b1;
                dev_rdata_i = req_addr ^ 32'hA5A5_0000;
                @(posedge clk_i);
                #5;
                dev_ready_i = 1'b0;
                dev_rdata_i = '0;
            end
        end
    end

    function automatic string op_name(input logic [7:0] op);
        case (op)
            "W":     return "write";
            "R":     return "read";
            "T":     return "timer irq";
            "S":     return "software irq";
            "M":     return "mtime load";
            default: return "unknown";
        endcase
    endfunction

    task automatic finish_run();
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d", checker0.tests,
                 checker0.tests - checker0.failed_tests, checker0.failed_tests,
                 checker0.errors);
        if (checker0.errors == 0 && checker0.tests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // Hard limit on the whole run
    initial begin : watchdog
        int n;
        n = 0;
        while (n < 20000) begin
            @(posedge clk_i);
            n++;
        end
        checker0.note_failure("simulation did not finish within 20000 cycles");
        finish_run();
    end

    // -----------------------------------------------------------------------
    // Pattern sequencer
    // -----------------------------------------------------------------------
    initial begin : stimulus
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [3:0]  b;
        logic [31:0] wd;
        logic [31:0] ex;
        logic [31:0] rd;
        logic        done;
        logic        level;
        logic        abort;
        reset_i     = 1'b1;
        req_i       = 1'b0;
        addr_i      = '0;
        rw_i        = 1'b0;
        be_i        = '0;
        wdata_i     = '0;
        dev_ready_i = 1'b0;
        dev_rdata_i = '0;
        repeat (10) @(posedge clk_i);
        #5;
        reset_i = 1'b0;
        @(negedge clk_i);
        checker0.begin_test("reset state");
        checker0.check_value("ready_o", {31'b0, ready_o}, 32'd0);
        checker0.check_value("dev_strobe_o", {31'b0, dev_strobe_o}, 32'd0);
        checker0.check_value("tmr_irq_o", {31'b0, tmr_irq_o}, 32'd0);
        checker0.check_value("sft_irq_o", {31'b0, sft_irq_o}, 32'd0);
        checker0.end_test();
        fd    = $fopen("verification/bus_patterns.txt", "r");
        abort = (fd == 0);
        if (abort) begin
            checker0.note_failure("pattern file verification/bus_patterns.txt did not open");
        end
        while (!abort && !$feof(fd)) begin
            n = $fgets(line, fd);
            // Comment and blank lines do not scan to five fields
            if (n > 0 && $sscanf(line, "%c %h %h %h %h", op, a, b, wd, ex) == 5) begin
                checker0.begin_test($sformatf("%s %h", op_name(op), a));
                done = 1'b1;
                case (op)
                    "W": run_access(1'b1, a, b, wd, rd, done);
                    "R": begin
                        run_access(1'b0, a, b, wd, rd, done);
                        if (done) checker0.check_value("rdata_o", rd, ex);
                    end
                    "T", "S": begin
                        run_access(1'b1, a, b, wd, rd, done);
                        if (done) begin
                            wait_irq(op == "T", ex[0], level);
                            checker0.check_value(op == "T" ? "tmr_irq_o" : "sft_irq_o",
                                                 {31'b0, level}, ex);
                        end
                    end
                    "M": begin
                        // Timer keeps counting from the loaded value
                        run_access(1'b1, a, b, wd, rd, done);
                        if (done) run_access(1'b0, a, b, 32'd0, rd, done);
                        if (done) checker0.check_range("rdata_o", rd, wd + 1, wd + 50);
                    end
                    default: checker0.note_failure("unknown operation in pattern file");
                endcase
                if (!done) begin
                    checker0.note_failure("ready_o did not arrive within 50 cycles");
                    abort = 1'b1;
                end
                #1;
                checker0.end_test();
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        finish_run();
    end

endmodule

// File: verification/bus_patterns.txt
# op address be wdata expected, all fields hex
# W write, R read and compare, T or S write then expect tmr_irq_o or sft_irq_o, M load mtime
W 00000010 f 11223344 00000000
R 00000010 f 00000000 11223344
W 00000010 6 aabbccdd 00000000
R 00000010 f 00000000 11bbcc44
W 00000010 1 000000ee 00000000
W 00000010 8 99000000 00000000
R 00000010 f 00000000 99bbccee
W 00000ffc f cafef00d 00000000
R 00000ffc f 00000000 cafef00d
W c0000100 3 deadbeef 00000000
R c0000104 f 00000000 65a50104
R c00010f0 f 00000000 65a510f0
W c0000200 c 12345678 00000000
R f0010000 f 00000000 00000000
R 80000040 f 00000000 00000000
R f0000008 f 00000000 ffffffff
W f0000008 f 12345678 00000000
R f0000008 f 00000000 12345678
W f0000008 f 00000000 00000000
T f000000c f 00000000 00000001
R f000000c f 00000000 00000000
T f000000c f ffffffff 00000000
S f0000010 f 00000001 00000001
R f0000010 f 00000000 00000001
S f0000010 f 00000000 00000000
M f0000000 f 00001000 00000000
R f0000014 f 00000000 00000000

// File: src.f
+incdir+hdl
hdl/aquila_pkg.sv
hdl/local_bus_if.sv
hdl/mtime_counter.sv
hdl/clint_regs.sv
hdl/tcm_ram.sv
hdl/data_bus_ctrl.sv
hdl/aquila_data_top.sv
verification/bus_checker.sv
verification/tb_aquila_data.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_aquila_data -o tb_aquila_data
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_aquila_data > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
exit 1
